// ==== Makefile ====
# Verilator build and run of the DSI lane controller testbench

TOP = tb_dsi_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_dsi_core.sv ====
//////////////////////////////
// testbench of the DSI lane controller
// APB tasks, register model, LFSR, checks, watchdog
//////////////////////////////

`timescale 1ns/1ps

module tb_dsi_core;

   import dsi_reg_pkg::*;

   localparam int          c_lanes           = 3;
   localparam int          c_half_period     = 20;
   localparam logic [31:0] c_lfsr_taps       = 32'h80200003;
   localparam int          c_reg_rounds      = 4;
   localparam int          c_unmapped_rounds = 4;
   localparam int          c_lane_rounds     = 8;
   localparam int          c_lp_rounds       = 4;
   localparam int          c_gpio_rounds     = 4;
   localparam int          c_access_cycles   = 4;
   // eight bits at the longest tick period
   localparam int          c_lp_byte_max     = 8 * 8;
   localparam int          c_test_cycles     = 8
      + c_access_cycles * (6 + c_reg_rounds * 12 + c_unmapped_rounds * 8 + 8 * 2
                           + c_lane_rounds * 3 + c_lp_rounds * 7 + 3 + c_gpio_rounds)
      + 8 * 2 + c_lane_rounds * 2 + c_gpio_rounds
      + c_lp_rounds * (c_lp_byte_max + 24 + 32) + 40;
   localparam int          c_watchdog_cycles = c_test_cycles + 8 * c_lp_byte_max + 100;

   logic                     clk_dsi;
   logic                     rst_n_dsi;
   apb_req_t                 apb_req;
   apb_rsp_t                 apb_rsp;
   logic [(c_lanes+1)*8-1:0] serdes_data;
   logic [c_lanes:0]         serdes_oe;
   logic [c_lanes-1:0]       dsi_lp_p;
   logic [c_lanes-1:0]       dsi_lp_n;
   logic [c_lanes-1:0]       dsi_lp_oe;
   logic                     dsi_clk_lp_p;
   logic                     dsi_clk_lp_n;
   logic                     dsi_clk_lp_oe;
   logic                     dsi_reset_n;
   logic [2:0]               dsi_gpio;

   int                       checks;
   int                       errors;
   logic [31:0]              lfsr;
   // negedge where the lines were back in LP-11
   time                      lp_idle_time;

   // expected register contents
   logic [11:0]              m_tick_div;
   logic                     m_clk_en;
   logic                     m_lp_request;
   logic [2:0]               m_num_lanes;
   logic [3:0]               m_gpio;
   logic [13:0]              m_lane_ctrl;
   logic [23:0]              m_pattern;

   dsi_core #(.g_lanes(c_lanes)) uut (
      .clk_dsi_i       (clk_dsi),
      .rst_n_dsi_i     (rst_n_dsi),
      .apb_req_i       (apb_req),
      .apb_rsp_o       (apb_rsp),
      .serdes_data_o   (serdes_data),
      .serdes_oe_o     (serdes_oe),
      .dsi_lp_p_o      (dsi_lp_p),
      .dsi_lp_n_o      (dsi_lp_n),
      .dsi_lp_oe_o     (dsi_lp_oe),
      .dsi_clk_lp_p_o  (dsi_clk_lp_p),
      .dsi_clk_lp_n_o  (dsi_clk_lp_n),
      .dsi_clk_lp_oe_o (dsi_clk_lp_oe),
      .dsi_reset_n_o   (dsi_reset_n),
      .dsi_gpio_o      (dsi_gpio)
   );

   always #(c_half_period) clk_dsi = ~clk_dsi;

   //////////////////////////////
   // concurrent checks
   //////////////////////////////

   // no wait states
   assert property (@(negedge clk_dsi) disable iff (!rst_n_dsi)
                    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
   else begin
      errors++;
      $display("FAILED pready got %h expected 1", apb_rsp.pready);
   end

   assert property (@(negedge clk_dsi) disable iff (!rst_n_dsi)
                    {dsi_clk_lp_p, dsi_clk_lp_n} == 2'b11)
   else begin
      errors++;
      $display("FAILED dsi_clk_lp_p/n got %h expected 3", {dsi_clk_lp_p, dsi_clk_lp_n});
   end

   assert property (@(negedge clk_dsi) disable iff (!rst_n_dsi)
                    dsi_clk_lp_oe == !m_clk_en)
   else begin
      errors++;
      $display("FAILED dsi_clk_lp_oe_o got %h expected %h", dsi_clk_lp_oe, !m_clk_en);
   end

   assert property (@(negedge clk_dsi) disable iff (!rst_n_dsi)
                    dsi_lp_oe == {c_lanes{m_lp_request}})
   else begin
      errors++;
      $display("FAILED dsi_lp_oe_o got %h expected %h", dsi_lp_oe, {c_lanes{m_lp_request}});
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? c_lfsr_taps : 32'h0);
      end
      return v;
   endfunction

   function automatic logic is_mapped(input logic [7:0] addr);
      return addr inside {REG_TICK_DIV, REG_DSI_CTL, REG_LP_TX, REG_GPIO, REG_LANE_CTRL,
                          REG_HS_PATTERN};
   endfunction

   // readback with the serializer idle
   function automatic logic [31:0] expected_read(input logic [7:0] addr);
      case (addr)
         REG_TICK_DIV:   return {20'b0, m_tick_div};
         REG_DSI_CTL:    return {21'b0, m_num_lanes, 5'b0, 1'b1, m_lp_request, m_clk_en};
         REG_GPIO:       return {28'b0, m_gpio};
         REG_LANE_CTRL:  return {18'b0, m_lane_ctrl};
         REG_HS_PATTERN: return {8'b0, m_pattern};
         default:        return 32'h0;
      endcase
   endfunction

   function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         REG_TICK_DIV: m_tick_div = data[11:0];
         REG_DSI_CTL: begin
            m_clk_en     = data[0];
            m_lp_request = data[1];
            m_num_lanes  = data[10:8];
         end
         REG_GPIO:       m_gpio = data[3:0];
         REG_LANE_CTRL:  m_lane_ctrl = data[13:0];
         REG_HS_PATTERN: m_pattern = data[23:0];
         default: ;
      endcase
   endfunction

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // setup phase, access phase, back to idle
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      logic err;
      @(posedge clk_dsi);
      apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
      @(posedge clk_dsi);
      apb_req.penable <= 1'b1;
      @(negedge clk_dsi);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk_dsi);
      apb_req <= '0;
      expect_equal($sformatf("pslverr at 0x%02h", addr), 32'(err), 32'(!is_mapped(addr)));
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused);
      model_write(addr, data);
   endtask

   task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] rd;
      apb_access(1'b0, addr, 32'h0, rd);
      expect_equal($sformatf("prdata at 0x%02h", addr), rd, exp);
   endtask

   task automatic read_all_regs;
      for (int k = 0; k < 6; k++) begin
         apb_read_check(8'(4 * k), expected_read(8'(4 * k)));
      end
   endtask

   task automatic lines_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk_dsi);
         expect_equal("dsi_lp_p_o", 32'(dsi_lp_p), 32'h7);
         expect_equal("dsi_lp_n_o", 32'(dsi_lp_n), 32'h7);
      end
   endtask

   //////////////////////////////
   // test sequences
   //////////////////////////////

   task automatic check_reset_state;
      @(negedge clk_dsi);
      expect_equal("serdes_data_o", 32'(serdes_data), 32'h0);
      expect_equal("serdes_oe_o", 32'(serdes_oe), 32'h0);
      expect_equal("dsi_lp_p_o", 32'(dsi_lp_p), 32'h7);
      expect_equal("dsi_lp_n_o", 32'(dsi_lp_n), 32'h7);
      expect_equal("dsi_reset_n_o", 32'(dsi_reset_n), 32'h0);
      expect_equal("dsi_gpio_o", 32'(dsi_gpio), 32'h0);
      read_all_regs();
   endtask

   task automatic random_register_rw;
      for (int r = 0; r < c_reg_rounds; r++) begin
         apb_write(REG_TICK_DIV, rand_bits(32));
         apb_write(REG_DSI_CTL, rand_bits(32));
         // valid clear, nothing is sent
         apb_write(REG_LP_TX, rand_bits(32) & ~32'h100);
         apb_write(REG_GPIO, rand_bits(32));
         apb_write(REG_LANE_CTRL, rand_bits(32));
         apb_write(REG_HS_PATTERN, rand_bits(32));
         read_all_regs();
      end
   endtask

   task automatic unmapped_access;
      logic [7:0]  addr;
      logic [31:0] rd;
      for (int r = 0; r < c_unmapped_rounds; r++) begin
         addr = 8'h18 + 8'(rand_bits(8) % 232);
         apb_access(1'b1, addr, rand_bits(32), rd);
         apb_access(1'b0, addr, 32'h0, rd);
         read_all_regs();
      end
   endtask

   task automatic clock_lane_combos;
      logic [2:0]  combo;
      logic [7:0]  exp_byte;
      logic [31:0] lane_word;
      for (int c = 0; c < 8; c++) begin
         // {invert, polarity, clk_en}
         combo     = 3'(c);
         lane_word = {18'b0, combo[1], combo[2], m_lane_ctrl[11:0]};
         apb_write(REG_LANE_CTRL, lane_word);
         apb_write(REG_DSI_CTL, {21'b0, m_num_lanes, 6'b0, m_lp_request, combo[0]});
         exp_byte = combo[0] ? (combo[1] ? 8'h55 : 8'hAA) : 8'h00;
         if (combo[2]) begin
            exp_byte = ~exp_byte;
         end
         @(posedge clk_dsi);
         @(negedge clk_dsi);
         expect_equal("serdes_data_o clock byte", 32'(serdes_data[c_lanes*8 +: 8]),
                      32'(exp_byte));
         expect_equal("serdes_oe_o clock bit", 32'(serdes_oe[c_lanes]), 32'(combo[0]));
      end
   endtask

   task automatic data_lane_steering;
      int         sel;
      logic [7:0] exp_byte;
      for (int r = 0; r < c_lane_rounds; r++) begin
         apb_write(REG_HS_PATTERN, rand_bits(24));
         apb_write(REG_LANE_CTRL, rand_bits(14));
         apb_write(REG_DSI_CTL, rand_bits(11) & 32'h703);
         @(posedge clk_dsi);
         @(negedge clk_dsi);
         for (int i = 0; i < c_lanes; i++) begin
            sel = int'(m_lane_ctrl[2*i +: 2]);
            if ((sel == 3) || (i >= int'(m_num_lanes))) begin
               exp_byte = 8'h00;
            end else begin
               exp_byte = m_pattern[8*sel +: 8];
            end
            if (m_lane_ctrl[8+i]) begin
               exp_byte = ~exp_byte;
            end
            expect_equal($sformatf("serdes_data_o lane %0d", i), 32'(serdes_data[8*i +: 8]),
                         32'(exp_byte));
            expect_equal($sformatf("serdes_oe_o lane %0d", i), 32'(serdes_oe[i]),
                         32'(!m_lp_request));
         end
      end
   endtask

   // watches the wire, MSB first, div+1 cycles per bit
   task automatic lp_monitor(input logic [7:0] data, input logic [7:0] mux,
                             input logic [2:0] div);
      logic [c_lanes-1:0] sel_mask;
      logic [c_lanes-1:0] exp_p;
      logic [c_lanes-1:0] exp_n;
      int                 waited;
      int                 start_limit;
      for (int i = 0; i < c_lanes; i++) begin
         sel_mask[i] = (mux[2*i +: 2] == 2'b00);
      end
      waited      = 0;
      start_limit = 2 * (int'(div) + 1) + 8;
      @(negedge clk_dsi);
      while (((dsi_lp_p & dsi_lp_n & sel_mask) == sel_mask) && (waited < start_limit)) begin
         @(negedge clk_dsi);
         waited++;
      end
      checks++;
      assert (waited < start_limit)
      else begin
         errors++;
         $display("LP transmission did not start within %0d cycles", start_limit);
      end
      if (waited < start_limit) begin
         for (int b = 7; b >= 0; b--) begin
            exp_p = (sel_mask & {c_lanes{data[b]}}) | ~sel_mask;
            exp_n = (sel_mask & {c_lanes{~data[b]}}) | ~sel_mask;
            for (int c = 0; c <= int'(div); c++) begin
               expect_equal($sformatf("dsi_lp_p_o bit %0d", b), 32'(dsi_lp_p), 32'(exp_p));
               expect_equal($sformatf("dsi_lp_n_o bit %0d", b), 32'(dsi_lp_n), 32'(exp_n));
               @(negedge clk_dsi);
            end
         end
         expect_equal("dsi_lp_p_o after byte", 32'(dsi_lp_p), 32'h7);
         expect_equal("dsi_lp_n_o after byte", 32'(dsi_lp_n), 32'h7);
      end
      lp_idle_time = $time;
   endtask

   // serializer busy, a second byte must be dropped
   // then poll until lp_ready comes back
   task automatic busy_refusal(input logic [7:0] data, output time ready_t);
      logic [31:0] rd;
      apb_access(1'b0, REG_DSI_CTL, 32'h0, rd);
      expect_equal("lp_ready while busy", 32'(rd[2]), 32'h0);
      apb_write(REG_LP_TX, {23'b0, 1'b1, ~data});
      rd = '0;
      while (!rd[2]) begin
         apb_access(1'b0, REG_DSI_CTL, 32'h0, rd);
      end
      // sampled on the negedge half a cycle earlier
      ready_t = $time - c_half_period;
   endtask

   task automatic lp_byte_transfer;
      logic [2:0] div;
      logic [7:0] data;
      logic [7:0] mux;
      time        ready_time;
      for (int r = 0; r < c_lp_rounds; r++) begin
         div  = 3'(rand_bits(3) % 7 + 1);
         data = 8'(rand_bits(8));
         mux  = 8'(rand_bits(8));
         if ((mux[1:0] != 2'b00) && (mux[3:2] != 2'b00) && (mux[5:4] != 2'b00)) begin
            mux[1:0] = 2'b00;
         end
         apb_write(REG_TICK_DIV, 32'(div));
         apb_write(REG_LANE_CTRL, 32'(mux));
         // LP mode, three lanes
         apb_write(REG_DSI_CTL, 32'h0000_0302);
         apb_write(REG_LP_TX, {23'b0, 1'b1, data});
         fork
            lp_monitor(data, mux, div);
            busy_refusal(data, ready_time);
         join
         // one poll every three cycles
         checks++;
         assert ((ready_time >= lp_idle_time) &&
                 (ready_time < lp_idle_time + 6 * c_half_period))
         else begin
            errors++;
            $display("lp_ready did not rise together with the return to LP-11");
         end
         apb_read_check(REG_DSI_CTL, expected_read(REG_DSI_CTL));
         lines_idle(4 * (int'(div) + 1));
      end
   endtask

   task automatic lp_mode_refusal;
      apb_write(REG_DSI_CTL, 32'h0000_0300);
      apb_write(REG_LP_TX, {23'b0, 1'b1, 8'(rand_bits(8))});
      lines_idle(4 * (int'(m_tick_div) + 1) + 4);
      apb_read_check(REG_DSI_CTL, expected_read(REG_DSI_CTL));
   endtask

   task automatic gpio_pins;
      for (int r = 0; r < c_gpio_rounds; r++) begin
         apb_write(REG_GPIO, rand_bits(4));
         @(negedge clk_dsi);
         expect_equal("dsi_reset_n_o", 32'(dsi_reset_n), 32'(m_gpio[0]));
         expect_equal("dsi_gpio_o", 32'(dsi_gpio), 32'(m_gpio[3:1]));
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      clk_dsi      = 1'b0;
      rst_n_dsi    = 1'b0;
      apb_req      = '0;
      lfsr         = 32'ha308f417;
      checks       = 0;
      errors       = 0;
      lp_idle_time = 0;
      m_tick_div   = '0;
      m_clk_en     = 1'b0;
      m_lp_request = 1'b0;
      m_num_lanes  = '0;
      m_gpio       = '0;
      m_lane_ctrl  = '0;
      m_pattern    = '0;
      repeat (5) @(posedge clk_dsi);
      rst_n_dsi <= 1'b1;

      check_reset_state();
      random_register_rw();
      unmapped_access();
      clock_lane_combos();
      data_lane_steering();
      lp_byte_transfer();
      lp_mode_refusal();
      gpio_pins();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #(c_watchdog_cycles * 2 * c_half_period);
      $display("watchdog expired after %0d cycles, checks %0d, errors %0d",
               c_watchdog_cycles, checks, errors);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== hdl/dsi_clock_lane.sv ====
//////////////////////////////
// HS clock lane pattern
// clock lane LP pins
//////////////////////////////

`timescale 1ns/1ps

module dsi_clock_lane (
   input  logic                    clk_dsi_i,
   input  logic                    rst_n_dsi_i,
   input  logic                    clk_en_i,
   input  logic                    clock_invert_i,
   input  logic                    clock_polarity_i,
   output dsi_phy_pkg::lane_byte_t data_o,
   output logic                    oe_o,
   output logic                    clk_lp_p_o,
   output logic                    clk_lp_n_o,
   output logic                    clk_lp_oe_o
);

   import dsi_phy_pkg::*;

   lane_byte_t pattern;

   always_comb begin
      if (!clk_en_i) begin
         pattern = '0;
      end else begin
         pattern = clock_polarity_i ? CLK_PATTERN_NEG : CLK_PATTERN_POS;
      end
      // inversion also applies to the stopped clock
      if (clock_invert_i) begin
         pattern = ~pattern;
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi_i) begin
         data_o <= '0;
         oe_o   <= 1'b0;
      end else begin
         data_o <= pattern;
         oe_o   <= clk_en_i;
      end
   end

   assign {clk_lp_p_o, clk_lp_n_o} = LP_STATE_STOP;
   assign clk_lp_oe_o = ~clk_en_i;

endmodule

// ==== hdl/dsi_core.sv ====
//////////////////////////////
// DSI transmitter lane controller top
//////////////////////////////

`timescale 1ns/1ps

module dsi_core #(
   parameter int g_lanes = 3
) (
   input  logic                      clk_dsi_i,
   input  logic                      rst_n_dsi_i,
   input  dsi_reg_pkg::apb_req_t     apb_req_i,
   output dsi_reg_pkg::apb_rsp_t     apb_rsp_o,
   // clock lane in the last byte
   output logic [(g_lanes+1)*8-1:0]  serdes_data_o,
   output logic [g_lanes:0]          serdes_oe_o,
   output logic [g_lanes-1:0]        dsi_lp_p_o,
   output logic [g_lanes-1:0]        dsi_lp_n_o,
   output logic [g_lanes-1:0]        dsi_lp_oe_o,
   output logic                      dsi_clk_lp_p_o,
   output logic                      dsi_clk_lp_n_o,
   output logic                      dsi_clk_lp_oe_o,
   output logic                      dsi_reset_n_o,
   output logic [2:0]                dsi_gpio_o
);

   import dsi_reg_pkg::*;
   import dsi_phy_pkg::*;

   dsi_ctl_t                 ctl;
   lane_ctrl_t               lane_cfg;
   logic [TICK_DIV_BITS-1:0] tick_div;
   logic [23:0]              hs_pattern;
   lp_tx_t                   lp_req;
   logic                     lp_ready;
   logic                     tick;

   dsi_csr_regs #(.g_lanes(g_lanes)) u_csr_regs (
      .clk_dsi_i     (clk_dsi_i),
      .rst_n_dsi_i   (rst_n_dsi_i),
      .apb_req_i     (apb_req_i),
      .apb_rsp_o     (apb_rsp_o),
      .lp_ready_i    (lp_ready),
      .ctl_o         (ctl),
      .lane_cfg_o    (lane_cfg),
      .tick_div_o    (tick_div),
      .hs_pattern_o  (hs_pattern),
      .lp_req_o      (lp_req),
      .dsi_reset_n_o (dsi_reset_n_o),
      .dsi_gpio_o    (dsi_gpio_o)
   );

   dsi_tick_gen u_tick_gen (
      .clk_dsi_i   (clk_dsi_i),
      .rst_n_dsi_i (rst_n_dsi_i),
      .tick_div_i  (tick_div),
      .tick_o      (tick)
   );

   dsi_lp_tx #(.g_lanes(g_lanes)) u_lp_tx (
      .clk_dsi_i   (clk_dsi_i),
      .rst_n_dsi_i (rst_n_dsi_i),
      .tick_i      (tick),
      .lp_req_i    (lp_req),
      .lane_mux_i  (lane_cfg.lane_mux),
      .lp_ready_o  (lp_ready),
      .lp_p_o      (dsi_lp_p_o),
      .lp_n_o      (dsi_lp_n_o)
   );

   dsi_lane_map #(.g_lanes(g_lanes)) u_lane_map (
      .clk_dsi_i    (clk_dsi_i),
      .rst_n_dsi_i  (rst_n_dsi_i),
      .hs_pattern_i (hs_pattern),
      .lane_cfg_i   (lane_cfg),
      .num_lanes_i  (ctl.num_lanes),
      .lp_request_i (ctl.lp_request),
      .data_o       (serdes_data_o[g_lanes*8-1:0]),
      .oe_o         (serdes_oe_o[g_lanes-1:0])
   );

   dsi_clock_lane u_clock_lane (
      .clk_dsi_i        (clk_dsi_i),
      .rst_n_dsi_i      (rst_n_dsi_i),
      .clk_en_i         (ctl.clk_en),
      .clock_invert_i   (lane_cfg.clock_invert),
      .clock_polarity_i (lane_cfg.clock_polarity),
      .data_o           (serdes_data_o[g_lanes*8 +: 8]),
      .oe_o             (serdes_oe_o[g_lanes]),
      .clk_lp_p_o       (dsi_clk_lp_p_o),
      .clk_lp_n_o       (dsi_clk_lp_n_o),
      .clk_lp_oe_o      (dsi_clk_lp_oe_o)
   );

   // LP drivers on all data lanes follow the LP mode request
   assign dsi_lp_oe_o = {g_lanes{ctl.lp_request}};

endmodule

// ==== hdl/dsi_csr_regs.sv ====
//////////////////////////////
// APB slave and control register file
// LP_TX acceptance and LP request pulse
//////////////////////////////

`timescale 1ns/1ps

module dsi_csr_regs #(
   parameter int g_lanes = 3
) (
   input  logic                                   clk_dsi_i,
   input  logic                                   rst_n_dsi_i,
   input  dsi_reg_pkg::apb_req_t                  apb_req_i,
   output dsi_reg_pkg::apb_rsp_t                  apb_rsp_o,
   input  logic                                   lp_ready_i,
   output dsi_reg_pkg::dsi_ctl_t                  ctl_o,
   output dsi_reg_pkg::lane_ctrl_t                lane_cfg_o,
   output logic [dsi_reg_pkg::TICK_DIV_BITS-1:0]  tick_div_o,
   output logic [23:0]                            hs_pattern_o,
   output dsi_phy_pkg::lp_tx_t                    lp_req_o,
   output logic                                   dsi_reset_n_o,
   output logic [2:0]                             dsi_gpio_o
);

   import dsi_reg_pkg::*;
   import dsi_phy_pkg::*;

   localparam logic [2:0] c_lanes = 3'(g_lanes);

   logic                     access;
   logic                     wr_en;
   logic                     mapped;
   logic                     lp_accept;
   logic [31:0]              rdata;

   logic [TICK_DIV_BITS-1:0] tick_div_q;
   logic                     clk_en_q;
   logic                     lp_request_q;
   logic [2:0]               num_lanes_q;
   gpio_t                    gpio_q;
   lane_ctrl_t               lane_cfg_q;
   logic [23:0]              hs_pattern_q;
   logic                     lp_valid_q;
   lane_byte_t               lp_data_q;

   //////////////////////////////
   // bus decode
   //////////////////////////////

   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;

   // LP byte only while in LP mode and the serializer is idle
   assign lp_accept = wr_en && (apb_req_i.paddr == REG_LP_TX) && apb_req_i.pwdata[8] &&
                      lp_request_q && lp_ready_i;

   always_comb begin
      mapped = 1'b1;
      rdata  = '0;
      case (apb_req_i.paddr)
         REG_TICK_DIV:   rdata = 32'(tick_div_q);
         REG_DSI_CTL:    rdata = {21'b0, num_lanes_q, 5'b0, lp_ready_i, lp_request_q, clk_en_q};
         REG_LP_TX:      rdata = '0;
         REG_GPIO:       rdata = 32'(gpio_q);
         REG_LANE_CTRL:  rdata = 32'(lane_cfg_q);
         REG_HS_PATTERN: rdata = {8'b0, hs_pattern_q};
         default:        mapped = 1'b0;
      endcase
   end

   assign apb_rsp_o = '{prdata: rdata, pready: access, pslverr: access & ~mapped};

   //////////////////////////////
   // registers
   //////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi_i) begin
         tick_div_q   <= '0;
         clk_en_q     <= 1'b0;
         lp_request_q <= 1'b0;
         num_lanes_q  <= '0;
         gpio_q       <= '0;
         lane_cfg_q   <= '0;
         hs_pattern_q <= '0;
         lp_valid_q   <= 1'b0;
      end else begin
         lp_valid_q <= lp_accept;
         if (wr_en) begin
            case (apb_req_i.paddr)
               REG_TICK_DIV: tick_div_q <= apb_req_i.pwdata[TICK_DIV_BITS-1:0];
               REG_DSI_CTL: begin
                  clk_en_q     <= apb_req_i.pwdata[0];
                  lp_request_q <= apb_req_i.pwdata[1];
                  num_lanes_q  <= apb_req_i.pwdata[10:8];
               end
               REG_GPIO:       gpio_q <= gpio_t'(apb_req_i.pwdata[$bits(gpio_t)-1:0]);
               REG_LANE_CTRL:  lane_cfg_q <=
                                  lane_ctrl_t'(apb_req_i.pwdata[$bits(lane_ctrl_t)-1:0]);
               REG_HS_PATTERN: hs_pattern_q <= apb_req_i.pwdata[23:0];
               default: ;
            endcase
         end
      end
   end

   // byte held for the serializer load
   always_ff @(posedge clk_dsi_i) begin
      if (lp_accept) begin
         lp_data_q <= apb_req_i.pwdata[7:0];
      end
   end

   // lanes above the instantiated count never exist downstream
   assign ctl_o = '{num_lanes:  (num_lanes_q > c_lanes) ? c_lanes : num_lanes_q,
                    lp_ready:   lp_ready_i,
                    lp_request: lp_request_q,
                    clk_en:     clk_en_q};

   assign lane_cfg_o    = lane_cfg_q;
   assign tick_div_o    = tick_div_q;
   assign hs_pattern_o  = hs_pattern_q;
   assign lp_req_o      = '{data: lp_data_q, valid: lp_valid_q};
   assign dsi_reset_n_o = gpio_q.dsi_reset_n;
   assign dsi_gpio_o    = gpio_q.gpio;

endmodule

// ==== hdl/dsi_lane_map.sv ====
//////////////////////////////
// HS data lane steering
// byte select, lane count mask, inversion
//////////////////////////////

`timescale 1ns/1ps

module dsi_lane_map #(
   parameter int g_lanes = 3
) (
   input  logic                                 clk_dsi_i,
   input  logic                                 rst_n_dsi_i,
   input  logic [23:0]                          hs_pattern_i,
   input  dsi_reg_pkg::lane_ctrl_t              lane_cfg_i,
   input  logic [2:0]                           num_lanes_i,
   input  logic                                 lp_request_i,
   output dsi_phy_pkg::lane_byte_t [g_lanes-1:0] data_o,
   output logic [g_lanes-1:0]                   oe_o
);

   import dsi_phy_pkg::*;

   lane_byte_t [g_lanes-1:0] data_next;

   always_comb begin
      logic [1:0] sel;
      lane_byte_t lane_byte;
      for (int i = 0; i < g_lanes; i++) begin
         sel = lane_cfg_i.lane_mux[2*i +: 2];
         // select 3 and disabled lanes carry zero
         if ((sel == 2'd3) || (i >= int'(num_lanes_i))) begin
            lane_byte = '0;
         end else begin
            lane_byte = hs_pattern_i[8*sel +: 8];
         end
         if (lane_cfg_i.lane_invert[i]) begin
            lane_byte = ~lane_byte;
         end
         data_next[i] = lane_byte;
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi_i) begin
         data_o <= '0;
         oe_o   <= '0;
      end else begin
         data_o <= data_next;
         oe_o   <= {g_lanes{~lp_request_i}};
      end
   end

endmodule

// ==== hdl/dsi_lp_tx.sv ====
//////////////////////////////
// low-power byte serializer
// MSB first, one bit per tick, lanes with mux 0 only
//////////////////////////////

`timescale 1ns/1ps

module dsi_lp_tx #(
   parameter int g_lanes = 3
) (
   input  logic                                  clk_dsi_i,
   input  logic                                  rst_n_dsi_i,
   input  logic                                  tick_i,
   input  dsi_phy_pkg::lp_tx_t                   lp_req_i,
   input  logic [2*dsi_phy_pkg::MAX_LANES-1:0]   lane_mux_i,
   output logic                                  lp_ready_o,
   output logic [g_lanes-1:0]                    lp_p_o,
   output logic [g_lanes-1:0]                    lp_n_o
);

   import dsi_phy_pkg::*;

   localparam int c_cnt_bits = $clog2(LP_BITS_PER_BYTE);
   localparam logic [c_cnt_bits-1:0] c_last_bit = c_cnt_bits'(LP_BITS_PER_BYTE - 1);

   logic                  busy_q;
   logic                  active_q;
   logic [c_cnt_bits-1:0] bit_cnt_q;
   lane_byte_t            shift_q;

   // busy waits for the first tick, active marks bits on the wire
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi_i) begin
         busy_q    <= 1'b0;
         active_q  <= 1'b0;
         bit_cnt_q <= '0;
      end else if (!busy_q) begin
         if (lp_req_i.valid) begin
            busy_q    <= 1'b1;
            bit_cnt_q <= '0;
         end
      end else if (tick_i) begin
         if (!active_q) begin
            active_q <= 1'b1;
         end else if (bit_cnt_q == c_last_bit) begin
            active_q <= 1'b0;
            busy_q   <= 1'b0;
         end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!busy_q && lp_req_i.valid) begin
         shift_q <= lp_req_i.data;
      end else if (active_q && tick_i) begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   assign lp_ready_o = ~busy_q;

   // idle lanes and unselected lanes sit in LP-11
   always_comb begin
      for (int i = 0; i < g_lanes; i++) begin
         if (active_q && (lane_mux_i[2*i +: 2] == 2'd0)) begin
            lp_p_o[i] = shift_q[7];
            lp_n_o[i] = ~shift_q[7];
         end else begin
            lp_p_o[i] = LP_STATE_STOP[1];
            lp_n_o[i] = LP_STATE_STOP[0];
         end
      end
   end

endmodule

// ==== hdl/dsi_phy_pkg.sv ====
//////////////////////////////
// D-PHY side definitions
// lane byte type, clock patterns, LP line states
//////////////////////////////

package dsi_phy_pkg;

   // one byte per lane per byte clock towards the SERDES
   typedef logic [7:0] lane_byte_t;

   // HS clock lane toggles every bit
   localparam lane_byte_t CLK_PATTERN_POS = 8'hAA;
   localparam lane_byte_t CLK_PATTERN_NEG = 8'h55;

   localparam int LP_BITS_PER_BYTE = 8;
   localparam int MAX_LANES        = 4;

   // LP-11 stop state, {p, n}
   localparam logic [1:0] LP_STATE_STOP = 2'b11;

   // low-power transmit request from the register file
   typedef struct packed {
      lane_byte_t data;
      logic       valid;
   } lp_tx_t;

endpackage

// ==== hdl/dsi_reg_pkg.sv ====
//////////////////////////////
// register map of the DSI lane controller
// control register fields and APB bus structs
//////////////////////////////

package dsi_reg_pkg;

   localparam int CSR_ADDR_BITS = 8;
   localparam int TICK_DIV_BITS = 12;

   // byte addresses
   localparam logic [CSR_ADDR_BITS-1:0] REG_TICK_DIV   = 8'h00;
   localparam logic [CSR_ADDR_BITS-1:0] REG_DSI_CTL    = 8'h04;
   localparam logic [CSR_ADDR_BITS-1:0] REG_LP_TX      = 8'h08;
   localparam logic [CSR_ADDR_BITS-1:0] REG_GPIO       = 8'h0C;
   localparam logic [CSR_ADDR_BITS-1:0] REG_LANE_CTRL  = 8'h10;
   localparam logic [CSR_ADDR_BITS-1:0] REG_HS_PATTERN = 8'h14;

   typedef struct packed {
      logic [2:0] num_lanes;
      logic       lp_ready;
      logic       lp_request;
      logic       clk_en;
   } dsi_ctl_t;

   // field order matches the LANE_CTRL bit layout
   typedef struct packed {
      logic       clock_polarity;
      logic       clock_invert;
      logic [3:0] lane_invert;
      logic [7:0] lane_mux;
   } lane_ctrl_t;

   // field order matches the GPIO bit layout
   typedef struct packed {
      logic [2:0] gpio;
      logic       dsi_reset_n;
   } gpio_t;

   typedef struct packed {
      logic [CSR_ADDR_BITS-1:0] paddr;
      logic                     psel;
      logic                     penable;
      logic                     pwrite;
      logic [31:0]              pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

endpackage

// ==== hdl/dsi_tick_gen.sv ====
//////////////////////////////
// LP bit-period tick divider
//////////////////////////////

`timescale 1ns/1ps

module dsi_tick_gen (
   input  logic                                  clk_dsi_i,
   input  logic                                  rst_n_dsi_i,
   input  logic [dsi_reg_pkg::TICK_DIV_BITS-1:0] tick_div_i,
   output logic                                  tick_o
);

   import dsi_reg_pkg::*;

   logic [TICK_DIV_BITS-1:0] count_q;

   // one pulse every tick_div_i + 1 cycles
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi_i) begin
         count_q <= '0;
         tick_o  <= 1'b0;
      end else if (count_q >= tick_div_i) begin
         count_q <= '0;
         tick_o  <= 1'b1;
      end else begin
         count_q <= count_q + 1'b1;
         tick_o  <= 1'b0;
      end
   end

endmodule

// ==== project.f ====
hdl/dsi_reg_pkg.sv
hdl/dsi_phy_pkg.sv
hdl/dsi_csr_regs.sv
hdl/dsi_tick_gen.sv
hdl/dsi_lp_tx.sv
hdl/dsi_lane_map.sv
hdl/dsi_clock_lane.sv
hdl/dsi_core.sv
bench/tb_dsi_core.sv
